// ==== logic/cdb_pkg.sv ====
package cdb_pkg;

    // datapath widths
    localparam int WORD_W     = 32;
    localparam int PREG_W     = 6;
    localparam int PREG_COUNT = 64; // 2**PREG_W

    // result sources: alu0, alu1, lsu, mdu
    localparam int FU_COUNT = 4;

    // source index wraps by truncation, so FU_COUNT stays a power of two
    localparam int FU_IDX_W = $clog2(FU_COUNT);

    // broadcast lanes per cycle
    localparam int CDB_COUNT = 2;

    // per-unit result buffering
    localparam int RESULT_FIFO_DEPTH = 2;

    // one result as it leaves a functional unit and as it rides the CDB
    typedef struct packed {
        logic [PREG_W-1:0] preg;   // destination physical register
        logic [WORD_W-1:0] w_data; // result value
        logic              w_reg;  // result writes preg
    } cdb_info_t;

endpackage

// ==== logic/result_fifo.sv ====
`timescale 1ns/1ns

module result_fifo #(
    parameter int DEPTH = cdb_pkg::RESULT_FIFO_DEPTH
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               flush_i,

    // write side, from the functional unit
    input  logic               push_i,
    input  cdb_pkg::cdb_info_t push_data_i,
    output logic               full_o,

    // read side, towards the CDB arbiter
    input  logic               pop_i,
    output logic               head_valid_o,
    output cdb_pkg::cdb_info_t head_o
);
    import cdb_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cdb_info_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // circular increment, DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full_o       = (count_q == CNT_W'(DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_o       = mem[rd_ptr_q]; // no bypass from push_data_i

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // drops the whole content and any push of this cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // unit must see ready low when full
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        push_i |-> !full_o
    ) else $error("result_fifo: push while full");

    // arbiter grants only non-empty heads
    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        pop_i |-> head_valid_o
    ) else $error("result_fifo: pop while empty");

endmodule

// ==== logic/cdb_arbiter.sv ====
`timescale 1ns/1ns

module cdb_arbiter (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    input  logic                                         flush_i,

    // result FIFO heads
    input  logic               [cdb_pkg::FU_COUNT-1:0]   head_valid_i,
    input  cdb_pkg::cdb_info_t [cdb_pkg::FU_COUNT-1:0]   head_i,
    output logic               [cdb_pkg::FU_COUNT-1:0]   pop_o,

    // registered broadcast lanes
    output logic               [cdb_pkg::CDB_COUNT-1:0]  cdb_valid_o,
    output cdb_pkg::cdb_info_t [cdb_pkg::CDB_COUNT-1:0]  cdb_o
);
    import cdb_pkg::*;

    logic [FU_IDX_W-1:0] ptr_q;    // first source to consider
    logic [FU_IDX_W-1:0] ptr_d;
    logic [FU_IDX_W-1:0] idx;      // scan position
    int unsigned         n_grant;  // lanes filled so far

    logic      [CDB_COUNT-1:0] lane_valid_d;
    cdb_info_t [CDB_COUNT-1:0] lane_d;
    logic      [CDB_COUNT-1:0] cdb_valid_q;
    cdb_info_t [CDB_COUNT-1:0] cdb_q;

    // rotating scan from ptr_q, first hit to lane 0, second to lane 1
    always_comb begin
        pop_o        = '0;
        lane_valid_d = '0;
        lane_d       = '0;
        ptr_d        = ptr_q;
        n_grant      = 0;
        idx          = ptr_q;
        for (int k = 0; k < FU_COUNT; k++) begin
            idx = ptr_q + FU_IDX_W'(k); // wraps by truncation
            if (head_valid_i[idx] && (n_grant < CDB_COUNT)) begin
                pop_o[idx] = 1'b1;
                for (int l = 0; l < CDB_COUNT; l++) begin
                    if (n_grant == l) begin
                        lane_valid_d[l] = 1'b1;
                        lane_d[l]       = head_i[idx];
                    end
                end
                ptr_d   = idx + 1'b1; // one past the last grant
                n_grant = n_grant + 1;
            end
        end
    end

    // control state
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q       <= '0;
            cdb_valid_q <= '0;
        end else if (flush_i) begin
            ptr_q       <= '0;
            cdb_valid_q <= '0;
        end else begin
            ptr_q       <= ptr_d;
            cdb_valid_q <= lane_valid_d;
        end
    end

    // lane payload, qualified by cdb_valid_q
    always_ff @(posedge clk_i) begin
        cdb_q <= lane_d;
    end

    assign cdb_valid_o = cdb_valid_q;
    assign cdb_o       = cdb_q;

    a_pop_valid_head: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (pop_o & ~head_valid_i) == '0
    ) else $error("cdb_arbiter: pop to empty FIFO");

    a_pop_count: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $countones(pop_o) <= CDB_COUNT
    ) else $error("cdb_arbiter: more pops than CDB lanes");

    // lanes fill in order, a lone result always rides lane 0
    a_lane_order: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        cdb_valid_o[1] |-> cdb_valid_o[0]
    ) else $error("cdb_arbiter: lane 1 valid without lane 0");

endmodule

// ==== logic/preg_ready_table.sv ====
`timescale 1ns/1ns

module preg_ready_table (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,

    // CDB broadcasts set entries ready
    input  logic               [cdb_pkg::CDB_COUNT-1:0]  cdb_valid_i,
    input  cdb_pkg::cdb_info_t [cdb_pkg::CDB_COUNT-1:0]  cdb_i,

    // dispatch allocation marks an entry busy
    input  logic                                         alloc_valid_i,
    input  logic               [cdb_pkg::PREG_W-1:0]     alloc_preg_i,

    // lookup
    input  logic               [cdb_pkg::PREG_W-1:0]     query_preg_i,
    output logic                                         query_ready_o
);
    import cdb_pkg::*;

    logic [PREG_COUNT-1:0] ready_q;
    logic [PREG_COUNT-1:0] ready_d;

    always_comb begin
        ready_d = ready_q;
        for (int l = 0; l < CDB_COUNT; l++) begin
            if (cdb_valid_i[l] && cdb_i[l].w_reg) begin
                ready_d[cdb_i[l].preg] = 1'b1;
            end
        end
        // a fresh allocation wins over a stale producer
        if (alloc_valid_i) begin
            ready_d[alloc_preg_i] = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q <= '1; // everything readable out of reset
        end else begin
            ready_q <= ready_d;
        end
    end

    assign query_ready_o = ready_q[query_preg_i];

    // rename never has two live producers for one preg
    a_lane_preg_unique: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (cdb_valid_i[0] && cdb_i[0].w_reg && cdb_valid_i[1] && cdb_i[1].w_reg)
            |-> (cdb_i[0].preg != cdb_i[1].preg)
    ) else $error("preg_ready_table: both lanes write preg %0d", cdb_i[0].preg);

endmodule

// ==== logic/writeback_top.sv ====
`timescale 1ns/1ns

module writeback_top (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    input  logic                                         flush_i,

    // functional unit results: alu0, alu1, lsu, mdu
    input  logic               [cdb_pkg::FU_COUNT-1:0]   fu_valid_i,
    input  cdb_pkg::cdb_info_t [cdb_pkg::FU_COUNT-1:0]   fu_result_i,
    output logic               [cdb_pkg::FU_COUNT-1:0]   fu_ready_o,

    // common data bus
    output logic               [cdb_pkg::CDB_COUNT-1:0]  cdb_valid_o,
    output cdb_pkg::cdb_info_t [cdb_pkg::CDB_COUNT-1:0]  cdb_o,

    // ready table access
    input  logic                                         alloc_valid_i,
    input  logic               [cdb_pkg::PREG_W-1:0]     alloc_preg_i,
    input  logic               [cdb_pkg::PREG_W-1:0]     query_preg_i,
    output logic                                         query_ready_o
);
    import cdb_pkg::*;

    logic      [FU_COUNT-1:0] fifo_push;
    logic      [FU_COUNT-1:0] fifo_full;
    logic      [FU_COUNT-1:0] head_valid;
    cdb_info_t [FU_COUNT-1:0] head;
    logic      [FU_COUNT-1:0] fifo_pop;

    for (genvar i = 0; i < FU_COUNT; i++) begin : g_fifo
        assign fu_ready_o[i] = ~fifo_full[i];
        assign fifo_push[i]  = fu_valid_i[i] & fu_ready_o[i]; // handshake

        result_fifo #(
            .DEPTH(RESULT_FIFO_DEPTH)
        ) u_fifo (
            .clk_i       (clk_i),
            .arst_n_i    (arst_n_i),
            .flush_i     (flush_i),
            .push_i      (fifo_push[i]),
            .push_data_i (fu_result_i[i]),
            .full_o      (fifo_full[i]),
            .pop_i       (fifo_pop[i]),
            .head_valid_o(head_valid[i]),
            .head_o      (head[i])
        );
    end

    cdb_arbiter u_arbiter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .head_valid_i(head_valid),
        .head_i      (head),
        .pop_o       (fifo_pop),
        .cdb_valid_o (cdb_valid_o),
        .cdb_o       (cdb_o)
    );

    // fed from the registered lanes, not from the FIFO heads
    preg_ready_table u_ready_table (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .cdb_valid_i  (cdb_valid_o),
        .cdb_i        (cdb_o),
        .alloc_valid_i(alloc_valid_i),
        .alloc_preg_i (alloc_preg_i),
        .query_preg_i (query_preg_i),
        .query_ready_o(query_ready_o)
    );

endmodule

// ==== include/writeback_tb_tasks.svh ====
`ifndef WRITEBACK_TB_TASKS_SVH
`define WRITEBACK_TB_TASKS_SVH

localparam int WAIT_LIMIT = 200; // cycles per wait loop

// reference model of the write-back path
cdb_info_t                 mq [FU_COUNT][$]; // expected FIFO contents
int                        m_ptr;            // expected arbiter pointer
logic [CDB_COUNT-1:0]      exp_valid;        // lanes expected after the last edge
cdb_info_t [CDB_COUNT-1:0] exp_lane;
logic [PREG_COUNT-1:0]     mr;               // expected ready bits

// stimulus and observation
cdb_info_t pend [FU_COUNT][$]; // results a unit still has to hand over
cdb_info_t acc_q [$];
cdb_info_t seen_q [$];
int        stall_cnt [FU_COUNT];
int        next_tag;
int        test_errs;
int        err_total;
int        tests_run;
int        tests_failed;

task automatic mismatch(input string msg);
    $display("ERR %0t: %s", $time, msg);
    test_errs++;
endtask

task automatic timed_out(input string what);
    $display("%0t: gave up after %0d cycles waiting for %s", $time, WAIT_LIMIT, what);
    test_errs++;
endtask

task automatic reset_model();
    for (int u = 0; u < FU_COUNT; u++) begin
        mq[u].delete();
        pend[u].delete();
    end
    m_ptr     = 0;
    exp_valid = '0;
    exp_lane  = '0;
    mr        = '1;
endtask

// unique tag in preg and in the top byte of the data
function automatic cdb_info_t make_result(input bit w_reg);
    cdb_info_t r;
    r.preg   = PREG_W'(next_tag);
    r.w_data = {8'(next_tag), 24'($urandom)};
    r.w_reg  = w_reg;
    next_tag++;
    return r;
endfunction

function automatic bit idle();
    for (int u = 0; u < FU_COUNT; u++) begin
        if (pend[u].size() != 0 || mq[u].size() != 0) begin
            return 1'b0;
        end
    end
    return exp_valid == '0;
endfunction

// one clock with the inputs already driven, model stepped alongside
task automatic tick();
    logic [FU_COUNT-1:0]       acc;
    logic [CDB_COUNT-1:0]      nv;
    cdb_info_t [CDB_COUNT-1:0] nl;
    int                        n;
    int                        idx;
    int                        last;
    acc  = fu_valid & fu_ready;
    nv   = '0;
    nl   = '0;
    n    = 0;
    last = m_ptr;
    for (int u = 0; u < FU_COUNT; u++) begin
        if (fu_ready[u] !== (mq[u].size() < RESULT_FIFO_DEPTH)) begin
            mismatch($sformatf("fu_ready_o[%0d] is %b with %0d entries held",
                u, fu_ready[u], mq[u].size()));
        end
        if (fu_valid[u] && !fu_ready[u]) begin
            stall_cnt[u]++;
        end
    end
    // lanes on the CDB now reach the table at this edge
    for (int l = 0; l < CDB_COUNT; l++) begin
        if (exp_valid[l] && exp_lane[l].w_reg) begin
            mr[exp_lane[l].preg] = 1'b1;
        end
    end
    if (alloc_valid) begin
        mr[alloc_preg] = 1'b0; // allocation wins
    end
    // scan from the pointer, first hit lane 0, second lane 1
    for (int k = 0; k < FU_COUNT; k++) begin
        idx = (m_ptr + k) % FU_COUNT;
        if (mq[idx].size() != 0 && n < CDB_COUNT) begin
            if (n == 0) begin
                nl[0] = mq[idx].pop_front();
            end else begin
                nl[1] = mq[idx].pop_front();
            end
            nv[n] = 1'b1;
            last  = idx;
            n++;
        end
    end
    if (n != 0) begin
        m_ptr = (last + 1) % FU_COUNT;
    end
    for (int u = 0; u < FU_COUNT; u++) begin
        if (acc[u] && !flush) begin
            mq[u].push_back(fu_result[u]); // no bypass, head from next cycle
        end
    end
    if (flush) begin
        for (int u = 0; u < FU_COUNT; u++) begin
            mq[u].delete();
        end
        m_ptr = 0;
        nv    = '0;
    end
    exp_valid = nv;
    exp_lane  = nl;
    @(negedge clk);
    for (int l = 0; l < CDB_COUNT; l++) begin
        if (cdb_valid[l] !== exp_valid[l]) begin
            mismatch($sformatf("cdb_valid_o[%0d] is %b, expected %b",
                l, cdb_valid[l], exp_valid[l]));
        end else if (exp_valid[l] && cdb[l] !== exp_lane[l]) begin
            mismatch($sformatf("lane %0d carries %h, expected %h", l, cdb[l], exp_lane[l]));
        end
        if (cdb_valid[l]) begin
            seen_q.push_back(cdb[l]);
        end
    end
    if (query_ready !== mr[query_preg]) begin
        mismatch($sformatf("preg %0d reads %b, expected %b",
            query_preg, query_ready, mr[query_preg]));
    end
endtask

// units present their pending results and hold them until accepted
task automatic pump(input int cycles, input bit drain);
    logic [FU_COUNT-1:0] acc;
    int                  t;
    t = 0;
    while (t < cycles && !(drain && idle())) begin
        for (int u = 0; u < FU_COUNT; u++) begin
            fu_valid[u] = (pend[u].size() != 0);
            if (fu_valid[u]) begin
                fu_result[u] = pend[u][0];
            end
        end
        acc = fu_valid & fu_ready;
        tick();
        for (int u = 0; u < FU_COUNT; u++) begin
            if (acc[u]) begin
                acc_q.push_back(pend[u].pop_front());
            end
        end
        t++;
    end
    fu_valid = '0;
    if (drain && !idle()) begin
        timed_out("the FIFOs and the CDB to drain");
    end
endtask

task automatic accept(input int u, input cdb_info_t r);
    bit done;
    int t;
    done         = 1'b0;
    t            = 0;
    fu_valid[u]  = 1'b1;
    fu_result[u] = r;
    while (!done && t < WAIT_LIMIT) begin
        done = fu_ready[u];
        tick();
        t++;
    end
    fu_valid[u] = 1'b0;
    if (!done) begin
        timed_out($sformatf("unit %0d to accept a result", u));
    end
endtask

// returns the number of edges waited
task automatic wait_broadcast(output int t);
    t = 0;
    while (cdb_valid[0] !== 1'b1 && t < WAIT_LIMIT) begin
        tick();
        t++;
    end
    if (cdb_valid[0] !== 1'b1) begin
        timed_out("a CDB broadcast");
    end
endtask

task automatic allocate(input logic [PREG_W-1:0] p);
    alloc_valid = 1'b1;
    alloc_preg  = p;
    tick();
    alloc_valid = 1'b0;
endtask

task automatic exactly_once();
    int hits;
    if (seen_q.size() != acc_q.size()) begin
        mismatch($sformatf("%0d broadcasts for %0d accepted results",
            seen_q.size(), acc_q.size()));
    end
    foreach (acc_q[i]) begin
        hits = 0;
        foreach (seen_q[j]) begin
            if (seen_q[j] == acc_q[i]) begin
                hits++;
            end
        end
        if (hits != 1) begin
            mismatch($sformatf("result %h seen %0d times", acc_q[i], hits));
        end
    end
endtask

task automatic begin_test();
    test_errs = 0;
    acc_q.delete();
    seen_q.delete();
    for (int u = 0; u < FU_COUNT; u++) begin
        stall_cnt[u] = 0;
    end
endtask

task automatic end_test(input string name);
    tests_run++;
    err_total += test_errs;
    if (test_errs == 0) begin
        $display("%s: ok", name);
    end else begin
        tests_failed++;
        $display("%s: %0d errors", name, test_errs);
    end
endtask

task automatic reset_state();
    begin_test();
    if (fu_ready !== '1) begin
        mismatch($sformatf("fu_ready_o is %b after reset", fu_ready));
    end
    if (cdb_valid !== '0) begin
        mismatch($sformatf("cdb_valid_o is %b after reset", cdb_valid));
    end
    for (int p = 0; p < PREG_COUNT; p++) begin
        query_preg = PREG_W'(p);
        tick();
    end
    end_test("reset state");
endtask

task automatic single_latency();
    cdb_info_t r;
    int        t;
    begin_test();
    r = make_result(1'b1);
    accept(1, r);
    wait_broadcast(t);
    if (t != 1) begin
        mismatch($sformatf("result on the CDB %0d edges after acceptance", t + 1));
    end
    if (cdb[0] !== r || cdb_valid[1] !== 1'b0) begin
        mismatch("single result not alone on lane 0");
    end
    pump(WAIT_LIMIT, 1'b1);
    end_test("single result latency");
endtask

task automatic round_robin_order();
    begin_test();
    for (int u = 0; u < FU_COUNT; u++) begin
        repeat (2) pend[u].push_back(make_result(1'b1));
    end
    pump(WAIT_LIMIT, 1'b1);
    exactly_once();
    end_test("round-robin order");
endtask

task automatic back_pressure();
    begin_test();
    repeat (6) pend[0].push_back(make_result(1'b1));
    for (int u = 1; u < FU_COUNT; u++) begin
        repeat (4) pend[u].push_back(make_result(u[0]));
    end
    pump(WAIT_LIMIT, 1'b1);
    if (stall_cnt[0] == 0) begin
        mismatch("fu_ready_o[0] never dropped");
    end
    exactly_once();
    end_test("back-pressure");
endtask

task automatic flush_discard();
    cdb_info_t a;
    cdb_info_t b;
    int        mark;
    int        pre;
    begin_test();
    for (int u = 0; u < FU_COUNT; u++) begin
        pend[u].push_back(make_result(1'b1));
    end
    // every head valid at the flush, so the grant there moves the pointer off 0
    pump(1, 1'b0);
    for (int u = 0; u < FU_COUNT; u++) begin
        pend[u].delete();
    end
    fu_valid[0]  = 1'b1; // push in the flush cycle, dropped
    fu_result[0] = make_result(1'b1);
    acc_q.push_back(fu_result[0]);
    flush = 1'b1;
    tick();
    flush    = 1'b0;
    fu_valid = '0;
    mark     = seen_q.size();
    pre      = acc_q.size();
    a        = make_result(1'b1);
    b        = make_result(1'b1);
    pend[0].push_back(a);
    pend[3].push_back(b);
    pump(WAIT_LIMIT, 1'b1);
    for (int j = mark; j < seen_q.size(); j++) begin
        for (int i = 0; i < pre; i++) begin
            if (seen_q[j] == acc_q[i]) begin
                mismatch($sformatf("result %h from before the flush broadcast", acc_q[i]));
            end
        end
    end
    if (seen_q.size() != mark + 2) begin
        mismatch($sformatf("%0d broadcasts after the flush", seen_q.size() - mark));
    end else if (seen_q[mark] !== a) begin
        mismatch("unit 0 result not on lane 0 after the flush");
    end
    end_test("flush");
endtask

task automatic ready_table_updates();
    logic [PREG_W-1:0] p;
    cdb_info_t         r;
    int                t;
    begin_test();
    p          = PREG_W'(45);
    query_preg = p;
    allocate(p);
    if (query_ready !== 1'b0) begin
        mismatch("allocated preg reads ready");
    end
    r      = make_result(1'b1);
    r.preg = p;
    pend[2].push_back(r);
    pump(WAIT_LIMIT, 1'b1);
    if (query_ready !== 1'b1) begin
        mismatch("preg still busy after its broadcast");
    end
    allocate(p);
    r      = make_result(1'b0);
    r.preg = p;
    pend[2].push_back(r);
    pump(WAIT_LIMIT, 1'b1);
    if (query_ready !== 1'b0) begin
        mismatch("broadcast without w_reg marked the preg ready");
    end
    r      = make_result(1'b1);
    r.preg = p;
    accept(0, r);
    wait_broadcast(t);
    allocate(p); // same cycle as the broadcast
    pump(WAIT_LIMIT, 1'b1);
    if (query_ready !== 1'b0) begin
        mismatch("broadcast won over a same-cycle allocation");
    end
    end_test("ready table");
endtask

`endif

// ==== tb/writeback_tb.sv ====
`timescale 1ns/1ns

module writeback_tb;
    import cdb_pkg::*;

    logic                      clk;
    logic                      arst_n;
    logic                      flush;
    logic [FU_COUNT-1:0]       fu_valid;
    cdb_info_t [FU_COUNT-1:0]  fu_result;
    logic [FU_COUNT-1:0]       fu_ready;
    logic [CDB_COUNT-1:0]      cdb_valid;
    cdb_info_t [CDB_COUNT-1:0] cdb;
    logic                      alloc_valid;
    logic [PREG_W-1:0]         alloc_preg;
    logic [PREG_W-1:0]         query_preg;
    logic                      query_ready;

    writeback_top i_dut (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .flush_i      (flush),
        .fu_valid_i   (fu_valid),
        .fu_result_i  (fu_result),
        .fu_ready_o   (fu_ready),
        .cdb_valid_o  (cdb_valid),
        .cdb_o        (cdb),
        .alloc_valid_i(alloc_valid),
        .alloc_preg_i (alloc_preg),
        .query_preg_i (query_preg),
        .query_ready_o(query_ready)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    `include "writeback_tb_tasks.svh"

    initial begin
        void'($urandom(32'hf33d));
        arst_n       = 1'b0;
        flush        = 1'b0;
        fu_valid     = '0;
        fu_result    = '0;
        alloc_valid  = 1'b0;
        alloc_preg   = '0;
        query_preg   = '0;
        next_tag     = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_total    = 0;
        reset_model();
        repeat (2) @(negedge clk); // two rising edges in reset
        arst_n = 1'b1;

        reset_state();
        single_latency();
        round_robin_order();
        back_pressure();
        flush_discard();
        ready_table_updates();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
logic/cdb_pkg.sv
logic/result_fifo.sv
logic/cdb_arbiter.sv
logic/preg_ready_table.sv
logic/writeback_top.sv
tb/writeback_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= writeback_tb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation completed successfully
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
